// ==== rtl/bus_pkg.sv ====
// ------------------------------
// Bus and address map definitions
// Address, region and byte-lane types
// Control-register region code
// Acknowledge state encoding
// ------------------------------
package bus_pkg;

   // Address map, decoded from the top bits of b
   //   b[31]    == 1   SRAM
   //   b[31:30] == 01  I/O devices
   //   b[31:28] == 2   Control registers (ctrlreg_we only, no strobe)
   // Anything else is internal block RAM, no bus cycle

   typedef logic [31:0] addr_t;      // Full b bus address
   typedef logic [3:0]  region_t;    // Top nibble, b[31:28]
   typedef logic [3:0]  byte_sel_t;  // Bit n enables byte lane n

   // Control registers live at 0x2xxxxxxx
   localparam region_t REGION_CTRL = 4'd2;

   // Held-acknowledge tracking
   // A slave on a point-to-point link may keep its ack high without wait
   // states, so an ack seen without a strobe moves us to ACK_HELD
   typedef enum logic {
      ACK_NORMAL = 1'b0,  // Ack only counts together with stb
      ACK_HELD   = 1'b1   // Ack stuck high, stb itself qualifies
   } ack_state_e;

endpackage

// ==== rtl/ucode_pkg.sv ====
// ------------------------------
// Microcode field definitions
// Access-width field type and codes
// ------------------------------
package ucode_pkg;

   // Access width of a store, built from the microcode strobes
   // {sa27, sa26, sa25, sa24}
   typedef logic [3:0] width_code_t;

   localparam width_code_t WIDTH_HALF = 4'b0001; // SH, two lanes
   localparam width_code_t WIDTH_BYTE = 4'b0010; // SB, one lane

   // Every other code is treated as a full word (SW, loads, etc)
   // so all four byte lanes are selected

endpackage

// ==== rtl/bus_cycle_if.sv ====
// ------------------------------
// Bus cycle status interface
// Strobes, write enable, qualified ack
// ------------------------------
`timescale 1ns/100ps

interface bus_cycle_if;

   logic stb;       // I/O strobe, held until qack
   logic sram_stb;  // SRAM strobe, held until sram_ack
   logic we;        // Write to I/O or SRAM
   logic qack;      // Qualified acknowledge

   // Strobe generator owns the cycle state
   modport strobe_mp (
      output stb, sram_stb, we,
      input  qack
   );

   // Ack qualifier needs the strobe only
   modport ack_mp (
      input  stb,
      output qack
   );

   // Microcode stall logic watches all cycle state
   modport progress_mp (
      input stb, sram_stb, we
   );

endinterface

// ==== rtl/byte_select.sv ====
// ------------------------------
// Byte lane selects for stores
// Registered sel_o and active-low bmask
// ------------------------------
`timescale 1ns/100ps

module byte_select (
   input  logic                   clk,
   input  logic                   RST_I,
   input  logic                   sa41,     // Latch new selects
   input  ucode_pkg::width_code_t width,    // Access width field
   input  logic [1:0]             addr_lo,  // b[1:0]
   output bus_pkg::byte_sel_t     sel_o,    // Byte selects, active high
   output bus_pkg::byte_sel_t     bmask     // Same, active low, for block RAM
);

   import bus_pkg::*;
   import ucode_pkg::*;

   byte_sel_t sel_dec; // Combinational decode

   // Width and offset to lane pattern
   always_comb begin
      case (width)
         WIDTH_HALF: begin
            case (addr_lo)
               2'd0:    sel_dec = 4'b0011;  // Lower half
               2'd2:    sel_dec = 4'b1100;  // Upper half
               default: sel_dec = 4'b1111;  // Odd halfword, fall back to word
            endcase
         end
         WIDTH_BYTE: sel_dec = byte_sel_t'(4'b0001 << addr_lo); // One-hot lane
         default:    sel_dec = 4'b1111;     // Full word
      endcase
   end

   // Both registers load together so they never disagree
   always_ff @(posedge clk) begin
      if (RST_I) begin
         sel_o <= 4'b0000;
         bmask <= 4'b1111;
      end else if (sa41) begin
         sel_o <= sel_dec;
         bmask <= ~sel_dec;
      end
   end

   // Block RAM mask must track the bus selects in every cycle
   a_bmask_inverse: assert property (
      @(posedge clk) disable iff (RST_I)
      bmask == ~sel_o
   );

endmodule

// ==== rtl/bus_strobe_gen.sv ====
// ------------------------------
// Bus strobe generation
// I/O and SRAM strobes held to ack
// Output and control-reg write enables
// Store alignment check
// ------------------------------
`timescale 1ns/100ps

module bus_strobe_gen #(
   parameter bit SRAM_EN = 1'b1  // 0 removes the SRAM strobe
) (
   input  logic            clk,
   input  logic            RST_I,
   input  logic            sa42,        // Start a bus cycle
   input  logic            sa43,        // Possibly set write enables
   input  logic            sa14,        // Clear write enables
   input  logic            sa30,        // SW, needs word alignment
   input  logic            nobuserror,
   input  bus_pkg::addr_t  addr,
   input  logic            sram_ack,
   bus_cycle_if.strobe_mp  bus,
   output logic            ctrlreg_we   // Write to control registers
);

   import bus_pkg::*;

   logic    misaligned;  // SW to address not word aligned
   logic    io_addr;
   logic    sram_addr;
   logic    wr_addr;     // Any address that takes a bus write
   logic    ctrl_addr;
   region_t region;
   logic    stb_nxt;
   logic    sram_stb_nxt;
   logic    clr_cycle;   // Reset or bus error

   assign region     = addr[31:28];
   assign misaligned = sa30 & (|addr[1:0]);
   assign io_addr    = ~addr[31] & addr[30];
   assign sram_addr  = addr[31] & SRAM_EN;   // Never SRAM when not built
   assign wr_addr    = addr[31] | addr[30];
   assign ctrl_addr  = (region == REGION_CTRL);
   assign clr_cycle  = RST_I | ~nobuserror;

   // Start on sa42, then hold until the matching acknowledge
   // SH needs no alignment check here, the decision comes later in ucode
   assign stb_nxt      = (sa42 & io_addr & ~misaligned)
                       | (bus.stb & ~bus.qack);
   assign sram_stb_nxt = (sa42 & sram_addr & ~misaligned)
                       | (bus.sram_stb & ~sram_ack);

   always_ff @(posedge clk) begin
      if (clr_cycle) begin
         bus.stb      <= 1'b0;
         bus.sram_stb <= 1'b0;
      end else begin
         bus.stb      <= stb_nxt;
         bus.sram_stb <= sram_stb_nxt;
      end
   end

   // Write enables
   // Set on sa43 for SRAM or I/O, dropped again by sa14
   always_ff @(posedge clk) begin
      if (clr_cycle | sa14) begin
         bus.we     <= 1'b0;
         ctrlreg_we <= 1'b0;
      end else if (sa43) begin  // nobuserror already high here
         bus.we     <= wr_addr & ~misaligned;
         ctrlreg_we <= ctrl_addr & ~misaligned;
      end
   end

   // I/O and SRAM decode are disjoint on b[31], so only one cycle at a time
   a_one_strobe: assert property (
      @(posedge clk) disable iff (RST_I)
      !(bus.stb && bus.sram_stb)
   );

   a_no_sram: assert property (
      @(posedge clk) disable iff (RST_I)
      SRAM_EN || !bus.sram_stb
   );

endmodule

// ==== rtl/ack_qualifier.sv ====
// ------------------------------
// Acknowledge qualification
// Held-ack FSM, qack output
// ------------------------------
`timescale 1ns/100ps

module ack_qualifier (
   input  logic         clk,
   input  logic         RST_I,
   input  logic         ack_i,      // Ack from I/O slave
   input  logic         sysregack,  // Ack from system registers
   bus_cycle_if.ack_mp  bus
);

   import bus_pkg::*;

   ack_state_e ack_state;
   ack_state_e ack_state_nxt;

   // An ack without a strobe means a broken or zero-wait slave
   // that keeps ack high. Stay in ACK_HELD while ack stays high,
   // go back as soon as it drops
   always_comb begin
      ack_state_nxt = ack_state;
      case (ack_state)
         ACK_NORMAL: begin
            if (ack_i && !bus.stb)
               ack_state_nxt = ACK_HELD;
         end
         ACK_HELD: begin
            if (!ack_i)
               ack_state_nxt = ACK_NORMAL;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (RST_I)
         ack_state <= ACK_NORMAL;
      else
         ack_state <= ack_state_nxt;
   end

   // Same-cycle qualified ack
   // In ACK_HELD the strobe stands in for the uninformative slave ack
   always_comb begin
      if (ack_state == ACK_HELD)
         bus.qack = sysregack | bus.stb;
      else
         bus.qack = sysregack | (ack_i & bus.stb);
   end

   // A stray ack must never end a cycle that was not started
   a_qack_source: assert property (
      @(posedge clk) disable iff (RST_I)
      bus.qack |-> (bus.stb || sysregack)
   );

endmodule

// ==== rtl/ucode_progress.sv ====
// ------------------------------
// Microcode progress control
// Q enable, progress, block RAM write
// ------------------------------
`timescale 1ns/100ps

module ucode_progress (
   input  logic              sa15,         // Part of Q enable
   input  logic              sa32,         // Read input, also enables Q
   input  logic              sa33,         // Repeat shift until done
   input  logic              sa41,         // Selects being set up, no EBR write
   input  logic              lastshift,
   input  logic              r_issh0_not,  // Low on shift by zero
   input  logic              nobuserror,
   input  logic              corerunning,
   bus_cycle_if.progress_mp  bus,
   output logic              ena_q,          // Sample ALU output into Q
   output logic              progress_ucode, // Step the microcode
   output logic              iwe             // Internal block RAM write
);

   logic cycle_active;  // Any strobe still waiting for its ack
   logic step_ok;       // Shift sequencing allows a step

   assign cycle_active = bus.stb | bus.sram_stb;

   // Q codes by {sa32, sa15}
   // 01 and 11 are normal Q updates, 10 is the extra read path
   assign ena_q = (sa15 | sa32) & ~lastshift & ~cycle_active;

   // No repeat requested, or the shift is finished, or nothing to shift
   assign step_ok = ~sa33 | lastshift | ~r_issh0_not;

   // Bus error must always let the microcode move on to its trap path
   assign progress_ucode = ~nobuserror | (step_ok & ~cycle_active);

   // Block RAM is written almost every cycle, except
   //   sa41 set (store setup), a bus write, or a shift by zero
   // corerunning guards the first active cycle after start
   assign iwe = corerunning & ~sa41 & ~bus.we & r_issh0_not;

endmodule

// ==== rtl/progress_ctrl.sv ====
// ------------------------------
// Progress and bus control, top
// Byte selects, strobes, write enables
// Qualified ack, microcode progress
// ------------------------------
`timescale 1ns/100ps

module progress_ctrl #(
   parameter bit SRAM_EN = 1'b1
) (
   input  logic               clk,
   input  logic               RST_I,
   input  logic               corerunning,
   input  logic               ack_i,
   input  logic               sysregack,
   input  logic               sram_ack,
   input  logic               sa14,
   input  logic               sa15,
   input  logic               sa24,
   input  logic               sa25,
   input  logic               sa26,
   input  logic               sa27,
   input  logic               sa30,
   input  logic               sa32,
   input  logic               sa33,
   input  logic               sa41,
   input  logic               sa42,
   input  logic               sa43,
   input  logic               lastshift,
   input  logic               r_issh0_not,
   input  logic               nobuserror,
   input  bus_pkg::addr_t     b,
   output bus_pkg::byte_sel_t sel_o,
   output bus_pkg::byte_sel_t bmask,
   output logic               iwe,
   output logic               ctrlreg_we,
   output logic               we_o,
   output logic               stb_o,
   output logic               sram_stb,
   output logic               ena_q,
   output logic               progress_ucode,
   output logic               qack
);

   import ucode_pkg::*;

   width_code_t width;

   bus_cycle_if bus_cycle ();  // Cycle status shared by the blocks below

   assign width = {sa27, sa26, sa25, sa24};

   byte_select byte_select_inst (
      .clk     (clk),
      .RST_I   (RST_I),
      .sa41    (sa41),
      .width   (width),
      .addr_lo (b[1:0]),
      .sel_o   (sel_o),
      .bmask   (bmask)
   );

   bus_strobe_gen #(
      .SRAM_EN (SRAM_EN)
   ) bus_strobe_gen_inst (
      .clk        (clk),
      .RST_I      (RST_I),
      .sa42       (sa42),
      .sa43       (sa43),
      .sa14       (sa14),
      .sa30       (sa30),
      .nobuserror (nobuserror),
      .addr       (b),
      .sram_ack   (sram_ack),
      .bus        (bus_cycle.strobe_mp),
      .ctrlreg_we (ctrlreg_we)
   );

   ack_qualifier ack_qualifier_inst (
      .clk       (clk),
      .RST_I     (RST_I),
      .ack_i     (ack_i),
      .sysregack (sysregack),
      .bus       (bus_cycle.ack_mp)
   );

   ucode_progress ucode_progress_inst (
      .sa15           (sa15),
      .sa32           (sa32),
      .sa33           (sa33),
      .sa41           (sa41),
      .lastshift      (lastshift),
      .r_issh0_not    (r_issh0_not),
      .nobuserror     (nobuserror),
      .corerunning    (corerunning),
      .bus            (bus_cycle.progress_mp),
      .ena_q          (ena_q),
      .progress_ucode (progress_ucode),
      .iwe            (iwe)
   );

   // Cycle status out as plain ports
   assign stb_o    = bus_cycle.stb;
   assign sram_stb = bus_cycle.sram_stb;
   assign we_o     = bus_cycle.we;
   assign qack     = bus_cycle.qack;

endmodule

// ==== testbench/tb_stimulus.sv ====
// ------------------------------
// Stimulus for progress_ctrl
// Directed bus cycles, ack cases
// Random byte selects and progress
// ------------------------------
`timescale 1ns/100ps

module tb_stimulus (
   input  logic           clk,
   input  logic           stb_o,     // Used only to pace random cycles
   input  logic           sram_stb,
   output logic           RST_I,
   output logic           corerunning,
   output logic           ack_i,
   output logic           sysregack,
   output logic           sram_ack,
   output logic           sa14, sa15, sa24, sa25, sa26, sa27, sa30,
   output logic           sa32, sa33, sa41, sa42, sa43,
   output logic           lastshift,
   output logic           r_issh0_not,
   output logic           nobuserror,
   output bus_pkg::addr_t b,
   output logic           done
);

   import bus_pkg::*;
   import ucode_pkg::*;

   integer seed;

   // Aligned address in the region given by kind (I/O, SRAM, ctrl regs, internal)
   function automatic addr_t pick_addr(input logic [1:0] kind);
      addr_t a;
      a      = $random(seed);
      a[1:0] = 2'b00;
      case (kind)
         2'd0:    a[31:30] = 2'b01;
         2'd1:    a[31]    = 1'b1;
         2'd2:    a[31:28] = REGION_CTRL;
         default: a[31:28] = 4'h0;
      endcase
      return a;
   endfunction

   // Halfword and byte codes show up more often than plain random
   function automatic width_code_t pick_width();
      logic [31:0] r;
      r = $random(seed);
      case (r[1:0])
         2'd0:    return WIDTH_HALF;
         2'd1:    return WIDTH_BYTE;
         default: return r[7:4];
      endcase
   endfunction

   // One strobe that is acked after wait_cycles
   task automatic bus_cycle(input logic sram, input int wait_cycles);
      @(posedge clk);
      b    <= pick_addr(sram ? 2'd1 : 2'd0);
      sa42 <= 1'b1;
      @(posedge clk);
      sa42 <= 1'b0;                          // Strobe rises on this edge
      repeat (wait_cycles) @(posedge clk);
      if (sram)
         sram_ack <= 1'b1;
      else
         ack_i <= 1'b1;
      @(posedge clk);
      sram_ack <= 1'b0;
      ack_i    <= 1'b0;
   endtask

   task automatic write_enable(input logic [1:0] kind, input logic [1:0] offset);
      @(posedge clk);
      b    <= pick_addr(kind) | addr_t'(offset);
      sa30 <= (offset != 2'b00);             // Nonzero offset makes a bad SW
      sa43 <= 1'b1;
      @(posedge clk);
      sa43 <= 1'b0;
      sa30 <= 1'b0;
      @(posedge clk);
      sa14 <= 1'b1;
      @(posedge clk);
      sa14 <= 1'b0;
   endtask

   task automatic random_mix(input int count);
      logic [31:0] r;
      repeat (count) begin
         @(posedge clk);
         r = $random(seed);
         sa15        <= r[0];
         sa32        <= r[1];
         sa33        <= r[2];
         sa41        <= r[3];
         lastshift   <= r[4];
         r_issh0_not <= r[5];
         corerunning <= r[6];
         nobuserror  <= (r[10:8] != 3'd0);   // Rare bus error
         ack_i       <= r[11];
         sram_ack    <= r[12];
         sysregack   <= (r[15:13] == 3'd0);
         sa43        <= (r[17:16] == 2'd0);  // sa43 and sa14 never together
         sa14        <= (r[17:16] == 2'd1);
         sa30        <= r[18];
         sa42        <= r[19] && !stb_o && !sram_stb && !sa42; // One cycle at a time
         b           <= pick_addr(r[21:20]) | addr_t'(r[23:22]);
         {sa27, sa26, sa25, sa24} <= pick_width();
      end
   endtask

   initial begin
      logic [31:0] r;
      seed = 32;
      RST_I       <= 1'b1;
      corerunning <= 1'b0;
      ack_i       <= 1'b0;
      sysregack   <= 1'b0;
      sram_ack    <= 1'b0;
      sa14        <= 1'b0;
      sa15        <= 1'b0;
      sa30        <= 1'b0;
      sa32        <= 1'b0;
      sa33        <= 1'b0;
      sa41        <= 1'b0;
      sa42        <= 1'b0;
      sa43        <= 1'b0;
      {sa27, sa26, sa25, sa24} <= 4'b0000;
      lastshift   <= 1'b0;
      r_issh0_not <= 1'b1;
      nobuserror  <= 1'b1;
      b           <= '0;
      done        <= 1'b0;
      repeat (8) @(posedge clk);
      RST_I <= 1'b0;
      repeat (2) @(posedge clk);

      // Byte selects with sa41 on about half the cycles
      repeat (40) begin
         @(posedge clk);
         b    <= $random(seed);
         r    = $random(seed);
         sa41 <= r[0];
         {sa27, sa26, sa25, sa24} <= pick_width();
      end
      @(posedge clk);
      sa41 <= 1'b0;

      // I/O strobes with varying ack delay
      repeat (5) bus_cycle(1'b0, $unsigned($random(seed)) % 8);
      @(posedge clk);                        // Misaligned SW starts nothing
      b    <= pick_addr(2'd0) | addr_t'(2'b10);
      sa30 <= 1'b1;
      sa42 <= 1'b1;
      @(posedge clk);
      sa30 <= 1'b0;
      sa42 <= 1'b0;
      repeat (3) @(posedge clk);
      b    <= pick_addr(2'd0);               // Bus error ends a waiting strobe
      sa42 <= 1'b1;
      @(posedge clk);
      sa42 <= 1'b0;
      repeat (2) @(posedge clk);
      nobuserror <= 1'b0;
      @(posedge clk);
      nobuserror <= 1'b1;

      // SRAM strobes
      repeat (5) bus_cycle(1'b1, $unsigned($random(seed)) % 8);

      // Write enables per region and two misaligned stores
      for (int k = 0; k < 4; k++)
         write_enable(k[1:0], 2'b00);
      write_enable(2'd0, 2'b01);
      write_enable(2'd2, 2'b11);

      // Ack qualification
      @(posedge clk);
      sysregack <= 1'b1;
      @(posedge clk);
      sysregack <= 1'b0;
      ack_i     <= 1'b1;                     // Held ack without a strobe
      repeat (3) @(posedge clk);
      b    <= pick_addr(2'd0);
      sa42 <= 1'b1;
      @(posedge clk);
      sa42 <= 1'b0;                          // qack in the first strobe cycle
      repeat (2) @(posedge clk);
      ack_i <= 1'b0;
      bus_cycle(1'b0, 3);                    // Normal qualification again

      random_mix(200);
      @(posedge clk);
      done <= 1'b1;
   end

endmodule

// ==== testbench/tb_progress_ctrl.sv ====
// ------------------------------
// Testbench top for progress_ctrl
// Clock, DUT, stimulus instance
// Reference model and assertions
// Timeout and end of run
// ------------------------------
`timescale 1ns/100ps

module tb_progress_ctrl;

   import bus_pkg::*;
   import ucode_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;  // About four times the stimulus length

   logic clk = 1'b0;
   logic RST_I, corerunning, ack_i, sysregack, sram_ack;
   logic sa14, sa15, sa24, sa25, sa26, sa27, sa30, sa32, sa33, sa41, sa42, sa43;
   logic lastshift, r_issh0_not, nobuserror;
   addr_t b;
   byte_sel_t sel_o, bmask;
   logic iwe, ctrlreg_we, we_o, stb_o, sram_stb, ena_q, progress_ucode, qack;
   logic done;  // Stimulus finished

   int unsigned cycles = 0;

   // Reference state
   byte_sel_t ref_sel, ref_bmask;
   logic ref_stb, ref_sram_stb, ref_we, ref_ctrlreg_we;
   logic ref_held;  // Slave ack seen without a strobe and still high
   logic ref_qack, ref_active, ref_ena_q, ref_progress, ref_iwe;
   logic misaligned, io_addr, sram_addr;

   always #4 clk = ~clk;  // 8 ns period

   progress_ctrl #(.SRAM_EN(1'b1)) progress_ctrl_inst (.*);

   tb_stimulus stimulus_inst (.*);

   task automatic stop_with_failure();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stop_with_failure();
   endtask

   // Lane decode from the width field and the low address bits
   function automatic byte_sel_t decode_sel(input width_code_t w, input logic [1:0] off);
      byte_sel_t sel;
      sel = 4'b1111;                        // Word and odd halfword
      if (w == WIDTH_HALF && off == 2'd0)
         sel = 4'b0011;
      else if (w == WIDTH_HALF && off == 2'd2)
         sel = 4'b1100;
      else if (w == WIDTH_BYTE) begin
         sel      = 4'b0000;
         sel[off] = 1'b1;                   // One lane
      end
      return sel;
   endfunction

   assign misaligned = sa30 && (b[1:0] != 2'b00);
   assign io_addr    = (b[31:30] == 2'b01);
   assign sram_addr  = b[31];

   // Combinational outputs in the same cycle
   assign ref_qack     = sysregack || (ref_held ? ref_stb : (ack_i && ref_stb));
   assign ref_active   = ref_stb || ref_sram_stb;
   assign ref_ena_q    = (sa15 || sa32) && !lastshift && !ref_active;
   assign ref_progress = !nobuserror || (!ref_active && (!sa33 || lastshift || !r_issh0_not));
   assign ref_iwe      = corerunning && !sa41 && !ref_we && r_issh0_not;

   always @(posedge clk) begin
      if (RST_I) begin
         ref_sel        <= 4'b0000;
         ref_bmask      <= 4'b1111;
         ref_stb        <= 1'b0;
         ref_sram_stb   <= 1'b0;
         ref_we         <= 1'b0;
         ref_ctrlreg_we <= 1'b0;
         ref_held       <= 1'b0;
      end else begin
         if (sa41) begin
            ref_sel   <= decode_sel({sa27, sa26, sa25, sa24}, b[1:0]);
            ref_bmask <= ~decode_sel({sa27, sa26, sa25, sa24}, b[1:0]);
         end
         if (!nobuserror) begin  // Bus error drops everything
            ref_stb        <= 1'b0;
            ref_sram_stb   <= 1'b0;
            ref_we         <= 1'b0;
            ref_ctrlreg_we <= 1'b0;
         end else begin
            ref_stb      <= (sa42 && io_addr && !misaligned) || (ref_stb && !ref_qack);
            ref_sram_stb <= (sa42 && sram_addr && !misaligned) || (ref_sram_stb && !sram_ack);
            if (sa14) begin
               ref_we         <= 1'b0;
               ref_ctrlreg_we <= 1'b0;
            end else if (sa43) begin
               ref_we         <= (sram_addr || io_addr) && !misaligned;
               ref_ctrlreg_we <= (b[31:28] == REGION_CTRL) && !misaligned;
            end
         end
         if (!ref_held)
            ref_held <= ack_i && !ref_stb;
         else
            ref_held <= ack_i;               // Leave once the ack drops
      end
   end

   // Registered outputs right after reset
   a_reset_values: assert property (@(posedge clk) $fell(RST_I) |->
      (sel_o == 4'b0000 && bmask == 4'b1111 && !stb_o && !sram_stb && !we_o && !ctrlreg_we))
      else report_mismatch("reset outputs", 32'h0f0,
         {$sampled(sel_o), $sampled(bmask), $sampled(stb_o), $sampled(sram_stb),
          $sampled(we_o), $sampled(ctrlreg_we)});

   a_sel: assert property (@(posedge clk) disable iff (RST_I) sel_o == ref_sel)
      else report_mismatch("sel_o", $sampled(ref_sel), $sampled(sel_o));
   a_bmask: assert property (@(posedge clk) disable iff (RST_I) bmask == ref_bmask)
      else report_mismatch("bmask", $sampled(ref_bmask), $sampled(bmask));
   a_stb: assert property (@(posedge clk) disable iff (RST_I) stb_o == ref_stb)
      else report_mismatch("stb_o", $sampled(ref_stb), $sampled(stb_o));
   a_sram_stb: assert property (@(posedge clk) disable iff (RST_I) sram_stb == ref_sram_stb)
      else report_mismatch("sram_stb", $sampled(ref_sram_stb), $sampled(sram_stb));
   a_we: assert property (@(posedge clk) disable iff (RST_I) we_o == ref_we)
      else report_mismatch("we_o", $sampled(ref_we), $sampled(we_o));
   a_ctrlreg_we: assert property (@(posedge clk) disable iff (RST_I)
      ctrlreg_we == ref_ctrlreg_we)
      else report_mismatch("ctrlreg_we", $sampled(ref_ctrlreg_we), $sampled(ctrlreg_we));
   a_qack: assert property (@(posedge clk) disable iff (RST_I) qack == ref_qack)
      else report_mismatch("qack", $sampled(ref_qack), $sampled(qack));
   a_ena_q: assert property (@(posedge clk) disable iff (RST_I) ena_q == ref_ena_q)
      else report_mismatch("ena_q", $sampled(ref_ena_q), $sampled(ena_q));
   a_progress: assert property (@(posedge clk) disable iff (RST_I)
      progress_ucode == ref_progress)
      else report_mismatch("progress_ucode", $sampled(ref_progress), $sampled(progress_ucode));
   a_iwe: assert property (@(posedge clk) disable iff (RST_I) iwe == ref_iwe)
      else report_mismatch("iwe", $sampled(ref_iwe), $sampled(iwe));

   // Guard against a stuck stimulus
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, stimulus never finished", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   initial begin
      wait (done);
      repeat (2) @(posedge clk);  // Let the last samples be checked
      @(negedge clk);             // Away from the edge the assertions sample on
      $display("all tests passed");
      $finish;
   end

endmodule

// ==== files.f ====
rtl/bus_pkg.sv
rtl/ucode_pkg.sv
rtl/bus_cycle_if.sv
rtl/byte_select.sv
rtl/bus_strobe_gen.sv
rtl/ack_qualifier.sv
rtl/ucode_progress.sv
rtl/progress_ctrl.sv
testbench/tb_stimulus.sv
testbench/tb_progress_ctrl.sv
